/* verilog/dec_cfg.svh */
/*
 decode stage configuration
 widths, register count and the fixed encodings shared by the decode stage
*/
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// data path and instruction widths
`define DEC_XLEN        32
`define DEC_INSTR_W     32

// register file geometry
`define DEC_REG_IDX_W   5
`define DEC_NUM_REGS    32

// destination index carries one extra bit
`define DEC_RD_W        6

// no destination, never equal to a 5-bit source index
`define DEC_NO_RD       6'd32

// return address step for jal/jalr
`define DEC_PC_STEP     32'd4

`endif

/* verilog/dec_pkg.sv */
/*
 decode stage types
 opcode and operation encodings plus the packed structs between the stages
*/
`include "dec_cfg.svh"

package dec_pkg;

	// rv32i major opcodes that this core decodes
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_ALU_IR = 7'b0010011,
		OP_ALU_RR = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} branch_op_e;

	typedef enum logic [1:0] {
		MEM_WORD, MEM_HALF, MEM_BYTE
	} mem_size_e;

	typedef struct packed {
		logic [`DEC_INSTR_W-1:0] instr;
		logic [`DEC_XLEN-1:0]    pc;
	} fetch_t;

	// forwarding source from ex or mem
	typedef struct packed {
		logic [`DEC_RD_W-1:0] rd;
		logic [`DEC_XLEN-1:0] data;
	} fwd_t;

	typedef struct packed {
		logic                      valid;
		logic [`DEC_REG_IDX_W-1:0] rd;
		logic [`DEC_XLEN-1:0]      data;
	} wb_t;

	typedef struct packed {
		alu_op_e              alu_op;
		branch_op_e           branch_op;
		logic                 load;
		logic                 store;
		mem_size_e            mem_size;
		logic                 mem_unsigned;
		logic                 jalr;
		logic                 only_src2_used;
		logic [`DEC_RD_W-1:0] rd;
		logic [`DEC_XLEN-1:0] pc;
		logic [`DEC_XLEN-1:0] imm;
	} ex_ctrl_t;

	typedef struct packed {
		logic [`DEC_XLEN-1:0] src1;
		logic [`DEC_XLEN-1:0] src2;
		logic [`DEC_XLEN-1:0] store_data;
	} ex_data_t;

	// decoder output, ex controls without pc plus operand routing
	typedef struct packed {
		alu_op_e                   alu_op;
		branch_op_e                branch_op;
		logic                      load;
		logic                      store;
		mem_size_e                 mem_size;
		logic                      mem_unsigned;
		logic                      jalr;
		logic                      only_src2_used;
		logic [`DEC_RD_W-1:0]      rd;
		logic [`DEC_XLEN-1:0]      imm;
		logic [`DEC_REG_IDX_W-1:0] rs1;
		logic [`DEC_REG_IDX_W-1:0] rs2;
		logic                      uses_rs1;
		logic                      uses_rs2;
		logic                      is_auipc;
		logic                      is_link;  // jal or jalr
		logic                      use_imm;
	} dec_ctrl_t;

endpackage

/* verilog/instr_decoder.sv */
/*
 instruction decoder
 maps an rv32i instruction onto alu, branch and load/store controls
 and builds the sign-extended immediate
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module instr_decoder (
	input  logic [`DEC_INSTR_W-1:0] instr,
	output dec_pkg::dec_ctrl_t      ctrl
);

	dec_pkg::opcode_e     opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [`DEC_RD_W-1:0] rd;
	logic [`DEC_XLEN-1:0] imm_i;
	logic [`DEC_XLEN-1:0] imm_s;
	logic [`DEC_XLEN-1:0] imm_b;
	logic [`DEC_XLEN-1:0] imm_j;
	logic [`DEC_XLEN-1:0] imm_u;
	dec_pkg::branch_op_e  br_op;
	dec_pkg::mem_size_e   mem_size;

	assign opcode = dec_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd     = {1'b0, instr[11:7]};

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	// funct3 low bits give the access width, bit 2 the unsigned load
	assign mem_size = (funct3[1:0] == 2'b00) ? dec_pkg::MEM_BYTE :
			  (funct3[1:0] == 2'b01) ? dec_pkg::MEM_HALF : dec_pkg::MEM_WORD;

	always_comb
	begin
		case (funct3)
			3'b000:  br_op = dec_pkg::BR_BEQ;
			3'b001:  br_op = dec_pkg::BR_BNE;
			3'b100:  br_op = dec_pkg::BR_BLT;
			3'b101:  br_op = dec_pkg::BR_BGE;
			3'b110:  br_op = dec_pkg::BR_BLTU;
			3'b111:  br_op = dec_pkg::BR_BGEU;
			default: br_op = dec_pkg::BR_NONE;
		endcase
	end

	// register-register ops need funct7 zero, except sub and sra
	function automatic dec_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic [6:0] f7,
		input logic is_rr);
		logic base_ok;
		logic alt;
		base_ok = !is_rr || (f7 == 7'b0000000);
		alt     = (f7 == 7'b0100000);
		case (f3)
			3'b000:  return (is_rr && alt) ? dec_pkg::ALU_SUB :
					(base_ok ? dec_pkg::ALU_ADD : dec_pkg::ALU_NOP);
			3'b001:  return base_ok ? dec_pkg::ALU_SLL : dec_pkg::ALU_NOP;
			3'b010:  return base_ok ? dec_pkg::ALU_SLT : dec_pkg::ALU_NOP;
			3'b011:  return base_ok ? dec_pkg::ALU_SLTU : dec_pkg::ALU_NOP;
			3'b100:  return base_ok ? dec_pkg::ALU_XOR : dec_pkg::ALU_NOP;
			3'b101:  return (f7 == 7'b0000000) ? dec_pkg::ALU_SRL :
					(alt ? dec_pkg::ALU_SRA : dec_pkg::ALU_NOP);
			3'b110:  return base_ok ? dec_pkg::ALU_OR : dec_pkg::ALU_NOP;
			default: return base_ok ? dec_pkg::ALU_AND : dec_pkg::ALU_NOP;
		endcase
	endfunction

	always_comb
	begin
		ctrl           = '0;
		ctrl.alu_op    = dec_pkg::ALU_NOP;
		ctrl.branch_op = dec_pkg::BR_NONE;
		ctrl.mem_size  = dec_pkg::MEM_WORD;
		ctrl.rd        = `DEC_NO_RD;  // overwritten by ops that write back
		ctrl.rs1       = instr[19:15];
		ctrl.rs2       = instr[24:20];
		case (opcode)
			dec_pkg::OP_LUI:
			begin
				ctrl.rd             = rd;
				ctrl.imm            = imm_u;
				ctrl.use_imm        = 1'b1;
				ctrl.only_src2_used = 1'b1;
			end
			dec_pkg::OP_AUIPC:
			begin
				ctrl.alu_op   = dec_pkg::ALU_ADD;
				ctrl.rd       = rd;
				ctrl.imm      = imm_u;
				ctrl.use_imm  = 1'b1;
				ctrl.is_auipc = 1'b1;
			end
			dec_pkg::OP_JAL:
			begin
				ctrl.rd             = rd;
				ctrl.imm            = imm_j;
				ctrl.is_link        = 1'b1;
				ctrl.only_src2_used = 1'b1;
			end
			dec_pkg::OP_JALR:
			begin
				ctrl.rd             = rd;
				ctrl.imm            = imm_i;  // target offset, used in ex
				ctrl.uses_rs1       = 1'b1;
				ctrl.is_link        = 1'b1;
				ctrl.jalr           = 1'b1;
				ctrl.only_src2_used = 1'b1;
			end
			dec_pkg::OP_BRANCH:
			begin
				ctrl.branch_op = br_op;
				ctrl.imm       = imm_b;
				ctrl.uses_rs1  = 1'b1;
				ctrl.uses_rs2  = 1'b1;
				case (br_op)
					dec_pkg::BR_BEQ, dec_pkg::BR_BNE:   ctrl.alu_op = dec_pkg::ALU_SUB;
					dec_pkg::BR_BLT, dec_pkg::BR_BGE:   ctrl.alu_op = dec_pkg::ALU_SLT;
					dec_pkg::BR_BLTU, dec_pkg::BR_BGEU: ctrl.alu_op = dec_pkg::ALU_SLTU;
					default:                            ctrl.alu_op = dec_pkg::ALU_NOP;
				endcase
			end
			dec_pkg::OP_LOAD:
			begin
				ctrl.alu_op       = dec_pkg::ALU_ADD;  // address calculation
				ctrl.load         = 1'b1;
				ctrl.mem_size     = mem_size;
				ctrl.mem_unsigned = funct3[2];
				ctrl.rd           = rd;
				ctrl.imm          = imm_i;
				ctrl.use_imm      = 1'b1;
				ctrl.uses_rs1     = 1'b1;
			end
			dec_pkg::OP_STORE:
			begin
				ctrl.alu_op   = dec_pkg::ALU_ADD;
				ctrl.store    = 1'b1;
				ctrl.mem_size = mem_size;
				ctrl.imm      = imm_s;
				ctrl.use_imm  = 1'b1;
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;  // store data
			end
			dec_pkg::OP_ALU_IR:
			begin
				ctrl.alu_op   = alu_of(funct3, funct7, 1'b0);
				ctrl.rd       = rd;
				ctrl.imm      = imm_i;
				ctrl.use_imm  = 1'b1;
				ctrl.uses_rs1 = 1'b1;
			end
			dec_pkg::OP_ALU_RR:
			begin
				ctrl.alu_op   = alu_of(funct3, funct7, 1'b1);
				ctrl.rd       = rd;
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;
			end
			default:
			begin
				ctrl.alu_op = dec_pkg::ALU_NOP;  // unknown opcode, no effect
			end
		endcase
	end

endmodule

/* verilog/gpr_file.sv */
/*
 general purpose register file
 31 writable registers, one write port from write-back, two async read ports
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module gpr_file (
	input  logic                      cpu_clk,
	input  logic                      cpu_rstn,
	input  dec_pkg::wb_t              wb,
	input  logic [`DEC_REG_IDX_W-1:0] rs1,
	input  logic [`DEC_REG_IDX_W-1:0] rs2,
	output logic [`DEC_XLEN-1:0]      rdata1,
	output logic [`DEC_XLEN-1:0]      rdata2
);

	logic [`DEC_XLEN-1:0] regs [1:`DEC_NUM_REGS-1];  // x0 has no storage
	logic                 wr_en;

	assign wr_en = wb.valid && (wb.rd != '0);  // writes to x0 dropped

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < `DEC_NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	// write-back must carry a known index and data
	wb_known: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		wb.valid |-> !$isunknown({wb.rd, wb.data}));

endmodule

/* verilog/operand_select.sv */
/*
 operand selection
 resolves both sources through the ex, mem and wb bypass paths
 and picks the alu operands and store data
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module operand_select (
	input  dec_pkg::dec_ctrl_t   ctrl,
	input  logic [`DEC_XLEN-1:0] pc,
	input  logic [`DEC_XLEN-1:0] rdata1,
	input  logic [`DEC_XLEN-1:0] rdata2,
	input  dec_pkg::fwd_t        ex_fwd,
	input  dec_pkg::fwd_t        mem_fwd,
	input  logic                 ex_is_load,
	input  dec_pkg::wb_t         wb,
	output dec_pkg::ex_data_t    data
);

	logic [`DEC_XLEN-1:0] rs1_val;
	logic [`DEC_XLEN-1:0] rs2_val;

	// youngest producer wins
	function automatic logic [`DEC_XLEN-1:0] resolve(
		input logic [`DEC_REG_IDX_W-1:0] idx,
		input logic [`DEC_XLEN-1:0]      file_data
	);
		logic [`DEC_RD_W-1:0] wide_idx;
		wide_idx = {1'b0, idx};
		if (idx == '0)
			return '0;
		else if (!ex_is_load && (wide_idx == ex_fwd.rd))
			return ex_fwd.data;  // a load in ex has no data yet
		else if (wide_idx == mem_fwd.rd)
			return mem_fwd.data;
		else if (wb.valid && (idx == wb.rd))
			return wb.data;
		else
			return file_data;
	endfunction

	always_comb
	begin
		rs1_val = resolve(ctrl.rs1, rdata1);
		rs2_val = resolve(ctrl.rs2, rdata2);

		if (ctrl.is_auipc)
			data.src1 = pc;
		else if (!ctrl.uses_rs1)
			data.src1 = '0;  // lui, jal
		else
			data.src1 = rs1_val;

		// link value for jal/jalr, otherwise immediate or rs2
		if (ctrl.is_link)
			data.src2 = pc + `DEC_PC_STEP;
		else if (ctrl.use_imm)
			data.src2 = ctrl.imm;
		else
			data.src2 = rs2_val;

		data.store_data = rs2_val;
	end

endmodule

/* verilog/load_hazard.sv */
/*
 load-use hazard detection
 stalls decode while a needed source is still being loaded in ex or mem
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module load_hazard (
	input  dec_pkg::dec_ctrl_t   ctrl,
	input  logic [`DEC_RD_W-1:0] ex_rd,
	input  logic                 ex_is_load,
	input  logic [`DEC_RD_W-1:0] mem_rd,
	input  logic                 load_wait_data,
	output logic                 dec_stall
);

	logic [`DEC_RD_W-1:0] rs1_w;
	logic [`DEC_RD_W-1:0] rs2_w;
	logic                 rs1_live;
	logic                 rs2_live;
	logic                 hit_ex;
	logic                 hit_mem;

	always_comb
	begin
		rs1_w    = {1'b0, ctrl.rs1};
		rs2_w    = {1'b0, ctrl.rs2};
		rs1_live = ctrl.uses_rs1 && (ctrl.rs1 != '0);  // x0 never waits
		rs2_live = ctrl.uses_rs2 && (ctrl.rs2 != '0);

		// load one ahead, result not back before ex needs it
		hit_ex = ex_is_load && ((rs1_live && (rs1_w == ex_rd)) ||
					(rs2_live && (rs2_w == ex_rd)));
		// load two ahead, memory still busy
		hit_mem = load_wait_data && ((rs1_live && (rs1_w == mem_rd)) ||
					     (rs2_live && (rs2_w == mem_rd)));

		dec_stall = hit_ex || hit_mem;
	end

endmodule

/* verilog/dec_ex_reg.sv */
/*
 dec to ex pipeline register
 inserts bubbles on stall or empty fetch, flushes on redirect and holds
 under ex back-pressure
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_ex_reg (
	input  logic                 cpu_clk,
	input  logic                 cpu_rstn,
	input  logic                 if_valid,
	input  logic                 dec_stall,
	input  logic                 ex_ready,
	input  logic                 branch_taken_ex,
	input  logic                 exception_met,
	input  dec_pkg::dec_ctrl_t   ctrl,
	input  logic [`DEC_XLEN-1:0] pc,
	input  dec_pkg::ex_data_t    data,
	output logic                 dec_valid,
	output dec_pkg::ex_ctrl_t    ex_ctrl,
	output dec_pkg::ex_data_t    ex_data
);

	dec_pkg::alu_op_e     alu_op_q;
	dec_pkg::branch_op_e  branch_op_q;
	logic                 load_q;
	logic                 store_q;
	logic                 jalr_q;
	logic [`DEC_RD_W-1:0] rd_q;
	dec_pkg::mem_size_e   mem_size_q;
	logic                 mem_unsigned_q;
	logic                 only_src2_q;
	logic [`DEC_XLEN-1:0] pc_q;
	logic [`DEC_XLEN-1:0] imm_q;
	logic                 flush;
	logic                 bubble;
	logic                 take;

	assign flush  = branch_taken_ex || exception_met || jalr_q;  // jalr target known in ex
	assign bubble = !if_valid || dec_stall;
	assign take   = ex_ready && !bubble && !flush;

	// flush wins over back-pressure, bubble and flush load the same values
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dec_valid   <= 1'b0;
			alu_op_q    <= dec_pkg::ALU_NOP;
			branch_op_q <= dec_pkg::BR_NONE;
			load_q      <= 1'b0;
			store_q     <= 1'b0;
			jalr_q      <= 1'b0;
			rd_q        <= `DEC_NO_RD;
		end
		else if (flush || ex_ready)
		begin
			dec_valid   <= take;
			alu_op_q    <= take ? ctrl.alu_op : dec_pkg::ALU_NOP;
			branch_op_q <= take ? ctrl.branch_op : dec_pkg::BR_NONE;
			load_q      <= take && ctrl.load;
			store_q     <= take && ctrl.store;
			jalr_q      <= take && ctrl.jalr;
			rd_q        <= take ? ctrl.rd : `DEC_NO_RD;
		end
	end

	// payload only moves with a real instruction
	always_ff @(posedge cpu_clk)
	begin
		if (take)
		begin
			mem_size_q     <= ctrl.mem_size;
			mem_unsigned_q <= ctrl.mem_unsigned;
			only_src2_q    <= ctrl.only_src2_used;
			pc_q           <= pc;
			imm_q          <= ctrl.imm;
			ex_data        <= data;
		end
	end

	assign ex_ctrl = '{alu_op: alu_op_q, branch_op: branch_op_q, load: load_q, store: store_q,
			   mem_size: mem_size_q, mem_unsigned: mem_unsigned_q, jalr: jalr_q,
			   only_src2_used: only_src2_q, rd: rd_q, pc: pc_q, imm: imm_q};

	// ex stalled and no redirect, nothing may leave or change
	hold_under_backpressure: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		(!ex_ready && !flush) |=> ($stable(ex_ctrl) && $stable(dec_valid)));

endmodule

/* verilog/dec_stage.sv */
/*
 rv32i decode stage
 decoder, register file, bypass, load-use stall and the dec to ex register
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_stage (
	input  logic              cpu_clk,
	input  logic              cpu_rstn,
	input  logic              if_valid,
	input  dec_pkg::fetch_t   fetch,
	output logic              dec_ready,
	input  logic              ex_ready,
	input  logic              branch_taken_ex,
	input  logic              exception_met,
	input  logic              load_wait_data,
	input  dec_pkg::fwd_t     ex_fwd,
	input  dec_pkg::fwd_t     mem_fwd,
	input  dec_pkg::wb_t      wb,
	output logic              dec_valid,
	output dec_pkg::ex_ctrl_t ex_ctrl,
	output dec_pkg::ex_data_t ex_data
);

	dec_pkg::dec_ctrl_t   ctrl;
	logic [`DEC_XLEN-1:0] rdata1;
	logic [`DEC_XLEN-1:0] rdata2;
	dec_pkg::ex_data_t    data;
	logic                 dec_stall;

	instr_decoder u_decoder (.instr(fetch.instr), .ctrl(ctrl));

	gpr_file u_gpr (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb       (wb),
		.rs1      (ctrl.rs1),
		.rs2      (ctrl.rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2)
	);

	operand_select u_opsel (
		.ctrl       (ctrl),
		.pc         (fetch.pc),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.ex_fwd     (ex_fwd),
		.mem_fwd    (mem_fwd),
		.ex_is_load (ex_ctrl.load),  // registered load in ex
		.wb         (wb),
		.data       (data)
	);

	load_hazard u_hazard (
		.ctrl           (ctrl),
		.ex_rd          (ex_ctrl.rd),
		.ex_is_load     (ex_ctrl.load),
		.mem_rd         (mem_fwd.rd),
		.load_wait_data (load_wait_data),
		.dec_stall      (dec_stall)
	);

	dec_ex_reg u_dec_ex (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.if_valid        (if_valid),
		.dec_stall       (dec_stall),
		.ex_ready        (ex_ready),
		.branch_taken_ex (branch_taken_ex),
		.exception_met   (exception_met),
		.ctrl            (ctrl),
		.pc              (fetch.pc),
		.data            (data),
		.dec_valid       (dec_valid),
		.ex_ctrl         (ex_ctrl),
		.ex_data         (ex_data)
	);

	assign dec_ready = !dec_stall && ex_ready;

endmodule

/* verification/dec_stage_tb.sv */
/*
 decode stage testbench
 directed tests for decode, register read, bypass, load-use stall,
 control transfers, flush and back-pressure
*/
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_stage_tb;

	localparam int TIMEOUT_CYCLES = 40;
	localparam int NO_DEST = 32;  // rd value for no destination
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_ALU_IR = 7'b0010011;
	localparam logic [6:0] OPC_ALU_RR = 7'b0110011;

	logic              cpu_clk;
	logic              cpu_rstn;
	logic              if_valid;
	dec_pkg::fetch_t   fetch;
	logic              dec_ready;
	logic              ex_ready;
	logic              branch_taken_ex;
	logic              exception_met;
	logic              load_wait_data;
	dec_pkg::fwd_t     ex_fwd;
	dec_pkg::fwd_t     mem_fwd;
	dec_pkg::wb_t      wb;
	logic              dec_valid;
	dec_pkg::ex_ctrl_t ex_ctrl;
	dec_pkg::ex_data_t ex_data;

	logic [31:0] lfsr;
	logic [31:0] reg_model [0:31];  // expected register file contents
	int          checks;
	int          errors;
	int          timeouts;

	dec_stage dec_stage_i (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.if_valid        (if_valid),
		.fetch           (fetch),
		.dec_ready       (dec_ready),
		.ex_ready        (ex_ready),
		.branch_taken_ex (branch_taken_ex),
		.exception_met   (exception_met),
		.load_wait_data  (load_wait_data),
		.ex_fwd          (ex_fwd),
		.mem_fwd         (mem_fwd),
		.wb              (wb),
		.dec_valid       (dec_valid),
		.ex_ctrl         (ex_ctrl),
		.ex_data         (ex_data)
	);

	initial cpu_clk = 1'b0;
	always #10 cpu_clk = ~cpu_clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_word();
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < 32; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// rv32i instruction formats
	function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
		input int f3, input int rd, input logic [6:0] op);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_s(input int off, input int rs2, input int rs1,
		input int f3);
		return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
		input int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input int imm20, input int rd, input logic [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_j(input int off, input int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic write_reg(input int idx, input logic [31:0] val);
		@(posedge cpu_clk);
		#2;
		wb = '{valid: 1'b1, rd: idx[4:0], data: val};
		@(posedge cpu_clk);
		#2;
		wb.valid = 1'b0;
		if (idx[4:0] != 5'd0)
			reg_model[idx[4:0]] = val;
	endtask

	task automatic drive_instr(input logic [31:0] instr, input logic [31:0] pc);
		if_valid    = 1'b1;
		fetch.instr = instr;
		fetch.pc    = pc;
	endtask

	// dec_ready sampled mid-cycle, returns just after the accepting edge
	task automatic wait_accept(input string what);
		int n;
		n = 0;
		@(negedge cpu_clk);
		while (!dec_ready && n < TIMEOUT_CYCLES)
		begin
			@(negedge cpu_clk);
			n++;
		end
		if (!dec_ready)
		begin
			timeouts++;
			$display("timeout: decode stage never accepted the %s instruction", what);
		end
		@(posedge cpu_clk);
		#2;
		if_valid = 1'b0;
	endtask

	task automatic issue(input logic [31:0] instr, input logic [31:0] pc, input string what);
		@(posedge cpu_clk);
		#2;
		drive_instr(instr, pc);
		wait_accept(what);
	endtask

	task automatic expect_operands(input int rd, input logic [31:0] src1,
		input logic [31:0] src2, input string what);
		check(32'(dec_valid), 32'd1, {what, " dec_valid"});
		check(32'(ex_ctrl.rd), rd, {what, " rd"});
		check(ex_data.src1, src1, {what, " src1"});
		check(ex_data.src2, src2, {what, " src2"});
	endtask

	task automatic expect_issue(input dec_pkg::alu_op_e alu, input int rd,
		input logic [31:0] src1, input logic [31:0] src2, input string what);
		check(32'(ex_ctrl.alu_op), 32'(alu), {what, " alu_op"});
		expect_operands(rd, src1, src2, what);
	endtask

	// bubble, flush and reset all load the same values
	task automatic expect_bubble(input string what);
		check(32'(dec_valid), 32'd0, {what, " dec_valid"});
		check(32'(ex_ctrl.alu_op), 32'(dec_pkg::ALU_NOP), {what, " alu_op"});
		check(32'(ex_ctrl.branch_op), 32'(dec_pkg::BR_NONE), {what, " branch_op"});
		check(32'({ex_ctrl.load, ex_ctrl.store, ex_ctrl.jalr}), 32'd0, {what, " ld/st/jalr"});
		check(32'(ex_ctrl.rd), NO_DEST, {what, " rd"});
	endtask

	task automatic expect_mem(input logic ld, input logic st, input dec_pkg::mem_size_e size,
		input logic uns, input logic [31:0] imm, input string what);
		check(32'({ex_ctrl.load, ex_ctrl.store}), 32'({ld, st}), {what, " load/store"});
		check(32'(ex_ctrl.mem_size), 32'(size), {what, " mem_size"});
		check(32'(ex_ctrl.mem_unsigned), 32'(uns), {what, " mem_unsigned"});
		check(ex_ctrl.imm, imm, {what, " imm"});
	endtask

	task automatic alu_decode();
		for (int i = 1; i < 10; i++)
		begin
			write_reg(i, rand_word());
		end
		issue(enc_r(0, 2, 1, 0, 10, OPC_ALU_RR), 32'h1000, "add");
		expect_issue(dec_pkg::ALU_ADD, 10, reg_model[1], reg_model[2], "add");
		issue(enc_r(32, 4, 3, 0, 11, OPC_ALU_RR), 32'h1004, "sub");
		expect_issue(dec_pkg::ALU_SUB, 11, reg_model[3], reg_model[4], "sub");
		issue(enc_r(0, 6, 5, 4, 12, OPC_ALU_RR), 32'h1008, "xor");
		expect_issue(dec_pkg::ALU_XOR, 12, reg_model[5], reg_model[6], "xor");
		issue(enc_r(32, 8, 7, 5, 13, OPC_ALU_RR), 32'h100c, "sra");
		expect_issue(dec_pkg::ALU_SRA, 13, reg_model[7], reg_model[8], "sra");
		issue(enc_r(0, 9, 1, 3, 14, OPC_ALU_RR), 32'h1010, "sltu");
		expect_issue(dec_pkg::ALU_SLTU, 14, reg_model[1], reg_model[9], "sltu");
		issue(enc_i(-7, 2, 0, 15, OPC_ALU_IR), 32'h1014, "addi");
		expect_issue(dec_pkg::ALU_ADD, 15, reg_model[2], 32'hffff_fff9, "addi");
		issue(enc_i(12'h0f0, 3, 7, 16, OPC_ALU_IR), 32'h1018, "andi");
		expect_issue(dec_pkg::ALU_AND, 16, reg_model[3], 32'h0000_00f0, "andi");
		issue(enc_i(-1, 4, 2, 17, OPC_ALU_IR), 32'h101c, "slti");
		expect_issue(dec_pkg::ALU_SLT, 17, reg_model[4], 32'hffff_ffff, "slti");
		issue(enc_i(3, 5, 5, 18, OPC_ALU_IR), 32'h1020, "srli");
		expect_issue(dec_pkg::ALU_SRL, 18, reg_model[5], 32'd3, "srli");
	endtask

	task automatic memory_ops();
		issue(enc_i(-16, 6, 2, 12, OPC_LOAD), 32'h2000, "lw");
		expect_issue(dec_pkg::ALU_ADD, 12, reg_model[6], 32'hffff_fff0, "lw");
		expect_mem(1'b1, 1'b0, dec_pkg::MEM_WORD, 1'b0, 32'hffff_fff0, "lw");
		issue(enc_i(6, 7, 5, 13, OPC_LOAD), 32'h2004, "lhu");
		expect_issue(dec_pkg::ALU_ADD, 13, reg_model[7], 32'd6, "lhu");
		expect_mem(1'b1, 1'b0, dec_pkg::MEM_HALF, 1'b1, 32'd6, "lhu");
		issue(enc_i(2047, 1, 0, 14, OPC_LOAD), 32'h2008, "lb");
		expect_mem(1'b1, 1'b0, dec_pkg::MEM_BYTE, 1'b0, 32'h0000_07ff, "lb");
		issue(enc_s(-20, 3, 2, 2), 32'h200c, "sw");
		expect_issue(dec_pkg::ALU_ADD, NO_DEST, reg_model[2], 32'hffff_ffec, "sw");
		expect_mem(1'b0, 1'b1, dec_pkg::MEM_WORD, 1'b0, 32'hffff_ffec, "sw");
		check(ex_data.store_data, reg_model[3], "sw store_data");
		issue(enc_s(100, 4, 5, 0), 32'h2010, "sb");
		expect_mem(1'b0, 1'b1, dec_pkg::MEM_BYTE, 1'b0, 32'd100, "sb");
		check(ex_data.store_data, reg_model[4], "sb store_data");
		check(32'(ex_ctrl.rd), NO_DEST, "sb rd");
	endtask

	task automatic forwarding_priority();
		logic [31:0] ex_val;
		logic [31:0] mem_val;
		logic [31:0] wb_val;
		logic [31:0] stale_val;
		ex_val    = rand_word();
		mem_val   = rand_word();
		wb_val    = rand_word();
		stale_val = rand_word();
		ex_fwd  = '{rd: 6'd8, data: ex_val};
		mem_fwd = '{rd: 6'd8, data: mem_val};
		wb      = '{valid: 1'b1, rd: 5'd8, data: stale_val};  // lands in the file meanwhile
		issue(enc_r(0, 0, 8, 0, 15, OPC_ALU_RR), 32'h3000, "add via ex");
		expect_issue(dec_pkg::ALU_ADD, 15, ex_val, 32'd0, "ex bypass");
		ex_fwd.rd = `DEC_NO_RD;
		issue(enc_r(0, 0, 8, 0, 15, OPC_ALU_RR), 32'h3004, "add via mem");
		expect_issue(dec_pkg::ALU_ADD, 15, mem_val, 32'd0, "mem bypass");
		mem_fwd.rd = `DEC_NO_RD;
		wb.data    = wb_val;  // file still holds the older value this cycle
		drive_instr(enc_r(0, 0, 8, 0, 15, OPC_ALU_RR), 32'h3008);
		wait_accept("add via wb");
		expect_issue(dec_pkg::ALU_ADD, 15, wb_val, 32'd0, "wb bypass");
		wb.valid     = 1'b0;
		reg_model[8] = wb_val;  // written at the accepting edge
		issue(enc_r(0, 0, 8, 0, 15, OPC_ALU_RR), 32'h300c, "add via file");
		expect_issue(dec_pkg::ALU_ADD, 15, reg_model[8], 32'd0, "register file read");
		// every bypass aimed at x0
		ex_fwd  = '{rd: 6'd0, data: ex_val};
		mem_fwd = '{rd: 6'd0, data: mem_val};
		wb      = '{valid: 1'b1, rd: 5'd0, data: wb_val};
		issue(enc_r(0, 0, 0, 0, 15, OPC_ALU_RR), 32'h3010, "add x0");
		expect_issue(dec_pkg::ALU_ADD, 15, 32'd0, 32'd0, "x0 read");
		ex_fwd.rd  = `DEC_NO_RD;
		mem_fwd.rd = `DEC_NO_RD;
		wb.valid   = 1'b0;
	endtask

	task automatic load_use_stall();
		logic [31:0] mem_data;
		mem_data = rand_word();
		issue(enc_i(0, 1, 2, 5, OPC_LOAD), 32'h4000, "lw x5");
		drive_instr(enc_r(0, 2, 5, 0, 16, OPC_ALU_RR), 32'h4004);  // needs x5 right away
		@(negedge cpu_clk);
		check(32'(dec_ready), 32'd0, "dec_ready with load in ex");
		@(posedge cpu_clk);
		#2;
		expect_bubble("bubble behind load");
		mem_fwd        = '{rd: 6'd5, data: 32'd0};
		load_wait_data = 1'b1;  // memory still busy
		for (int i = 0; i < 3; i++)
		begin
			@(negedge cpu_clk);
			check(32'(dec_ready), 32'd0, "dec_ready while load waits");
			@(posedge cpu_clk);
			#2;
			expect_bubble("bubble while load waits");
		end
		load_wait_data = 1'b0;
		mem_fwd.data   = mem_data;
		wait_accept("add after load");
		expect_issue(dec_pkg::ALU_ADD, 16, mem_data, reg_model[2], "add using loaded x5");
		mem_fwd.rd = `DEC_NO_RD;
	endtask

	task automatic check_branch(input int f3, input dec_pkg::branch_op_e br,
		input dec_pkg::alu_op_e alu, input string what);
		issue(enc_b(-8, 4, 3, f3), 32'h5000, what);
		expect_issue(alu, NO_DEST, reg_model[3], reg_model[4], what);
		check(32'(ex_ctrl.branch_op), 32'(br), {what, " branch_op"});
		check(ex_ctrl.imm, 32'hffff_fff8, {what, " imm"});
	endtask

	task automatic control_transfers();
		check_branch(0, dec_pkg::BR_BEQ, dec_pkg::ALU_SUB, "beq");
		check_branch(1, dec_pkg::BR_BNE, dec_pkg::ALU_SUB, "bne");
		check_branch(4, dec_pkg::BR_BLT, dec_pkg::ALU_SLT, "blt");
		check_branch(5, dec_pkg::BR_BGE, dec_pkg::ALU_SLT, "bge");
		check_branch(6, dec_pkg::BR_BLTU, dec_pkg::ALU_SLTU, "bltu");
		check_branch(7, dec_pkg::BR_BGEU, dec_pkg::ALU_SLTU, "bgeu");
		issue(enc_j(2048, 1), 32'h0000_0100, "jal");
		expect_operands(1, 32'd0, 32'h0000_0104, "jal");  // link is pc + 4
		check(ex_ctrl.imm, 32'h0000_0800, "jal imm");
		check(32'(ex_ctrl.only_src2_used), 32'd1, "jal only_src2_used");
		issue(enc_i(12, 6, 0, 17, OPC_JALR), 32'h0000_0200, "jalr");
		expect_operands(17, reg_model[6], 32'h0000_0204, "jalr");
		check(32'(ex_ctrl.jalr), 32'd1, "jalr flag");
		check(32'(ex_ctrl.only_src2_used), 32'd1, "jalr only_src2_used");
		issue(enc_u(20'h12345, 18, OPC_AUIPC), 32'h0000_0300, "auipc");
		expect_issue(dec_pkg::ALU_ADD, 18, 32'h0000_0300, 32'h1234_5000, "auipc");
		check(32'(ex_ctrl.only_src2_used), 32'd0, "auipc only_src2_used");
		issue(enc_u(20'hfedcb, 19, OPC_LUI), 32'h0000_0304, "lui");
		expect_operands(19, 32'd0, 32'hfedc_b000, "lui");
		check(32'(ex_ctrl.only_src2_used), 32'd1, "lui only_src2_used");
	endtask

	task automatic flush_and_backpressure();
		issue(enc_i(5, 1, 0, 20, OPC_ALU_IR), 32'h6000, "addi");
		ex_ready = 1'b0;
		drive_instr(enc_r(0, 3, 2, 0, 21, OPC_ALU_RR), 32'h6004);
		for (int i = 0; i < 3; i++)
		begin
			@(negedge cpu_clk);
			check(32'(dec_ready), 32'd0, "dec_ready under back-pressure");
			@(posedge cpu_clk);
			#2;
			expect_issue(dec_pkg::ALU_ADD, 20, reg_model[1], 32'd5, "held addi");
			check(ex_ctrl.pc, 32'h6000, "held pc");
		end
		ex_ready = 1'b1;
		wait_accept("add after back-pressure");
		expect_issue(dec_pkg::ALU_ADD, 21, reg_model[2], reg_model[3], "add after hold");
		// taken branch in ex kills the instruction in decode
		branch_taken_ex = 1'b1;
		drive_instr(enc_r(32, 3, 2, 0, 24, OPC_ALU_RR), 32'h6008);
		@(posedge cpu_clk);
		#2;
		expect_bubble("branch flush");
		branch_taken_ex = 1'b0;
		wait_accept("sub after branch flush");
		expect_issue(dec_pkg::ALU_SUB, 24, reg_model[2], reg_model[3], "sub after flush");
		issue(enc_i(0, 1, 0, 22, OPC_JALR), 32'h7000, "jalr before flush");
		drive_instr(enc_r(0, 3, 2, 0, 23, OPC_ALU_RR), 32'h7004);  // wrong path
		@(posedge cpu_clk);
		#2;
		if_valid = 1'b0;
		expect_bubble("jalr flush");
	endtask

	initial
	begin
		lfsr            = 32'h46875f17;
		checks          = 0;
		errors          = 0;
		timeouts        = 0;
		cpu_rstn        = 1'b0;
		if_valid        = 1'b0;
		fetch           = '0;
		ex_ready        = 1'b1;
		branch_taken_ex = 1'b0;
		exception_met   = 1'b0;
		load_wait_data  = 1'b0;
		ex_fwd          = '{rd: `DEC_NO_RD, data: 32'd0};
		mem_fwd         = '{rd: `DEC_NO_RD, data: 32'd0};
		wb              = '0;
		for (int i = 0; i < 32; i++)
		begin
			reg_model[i] = '0;
		end
		repeat (16) @(posedge cpu_clk);
		#2;
		cpu_rstn = 1'b1;
		expect_bubble("after reset");

		alu_decode();
		memory_ops();
		forwarding_priority();
		load_use_stall();
		control_transfers();
		flush_and_backpressure();

		repeat (2) @(posedge cpu_clk);
		$display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* dec_stage.f */
+incdir+verilog
verilog/dec_pkg.sv
verilog/instr_decoder.sv
verilog/gpr_file.sv
verilog/operand_select.sv
verilog/load_hazard.sv
verilog/dec_ex_reg.sv
verilog/dec_stage.sv
verification/dec_stage_tb.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dec_stage_tb
FILELIST = dec_stage.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/dec_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
